// ==== logic/cadr_mem_pkg.sv ====
// widths, depths, word types and level-2 map entry fields for the memory side
`default_nettype none

package cadr_mem_pkg;

  // virtual and physical address widths
  localparam int va_bits          = 24;
  localparam int page_offset_bits = 8;
  localparam int pa_bits          = 22;

  // level-1 map, 2k x 5, indexed by va[23:13]
  localparam int l1_addr_bits  = 11;
  localparam int l1_entry_bits = 5;

  // level-2 map, 1k x 24, indexed by {l1 entry, va[12:8]}
  localparam int l2_addr_bits  = 10;
  localparam int l2_entry_bits = 24;
  localparam int l2_sel_bits   = l2_addr_bits - l1_entry_bits;

  // scratchpad memories
  localparam int a_addr_bits = 10;
  localparam int m_addr_bits = 5;
  localparam int word_bits   = 32;

  // level-2 entry fields
  localparam int l2_access_bit = 23;
  localparam int l2_write_bit  = 22;
  localparam int l2_page_lsb   = 0;
  localparam int l2_page_msb   = 13;

  // physical page number width, 14
  localparam int pa_page_bits = l2_page_msb - l2_page_lsb + 1;

  typedef logic [l1_entry_bits-1:0] l1_entry_t;
  typedef logic [l2_entry_bits-1:0] l2_entry_t;
  typedef logic [word_bits-1:0]     word_t;

endpackage

`default_nettype wire

// ==== logic/static_ram.sv ====
// zero-initialised static RAM with asynchronous read and write on rising WE_N
`default_nettype none

module static_ram #(
  parameter type word_t_p  = logic [31:0],
  parameter int  addr_bits = 10
) (
  input  logic                 WE_N,
  input  logic [addr_bits-1:0] addr,
  input  logic [addr_bits-1:0] waddr,
  input  word_t_p              wdata,
  input  logic                 ce_n,
  input  logic                 wr,
  output word_t_p              rdata
);

  word_t_p mem [2**addr_bits];

  // contents come up as zero like the board parts
  initial
  begin
    for (int i = 0; i < 2**addr_bits; i++)
    begin
      mem[i] = '0;
    end
  end

  // write commits on the strobe edge only with chip enable low
  always_ff @(posedge WE_N)
  begin
    if (!ce_n && wr)
    begin
      mem[waddr] <= wdata;
    end
  end

  // asynchronous read of the addressed word
  assign rdata = mem[addr];

endmodule

`default_nettype wire

// ==== logic/map_translate.sv ====
// two-level virtual to physical map with a two-stage lookup pipeline
`default_nettype none

module map_translate
  import cadr_mem_pkg::*;
(
  input  logic               WE_N,
  input  logic               rst_n,
  input  logic [va_bits-1:0] va,
  input  logic               lookup,
  input  logic               l1_we,
  input  l1_entry_t          l1_data,
  input  logic               l2_we,
  input  l2_entry_t          l2_data,
  output logic [pa_bits-1:0] pa,
  output logic               access,
  output logic               writable,
  output logic               pa_valid
);

  logic [l1_addr_bits-1:0]     l1_idx;
  l1_entry_t                   l1_rdata;
  logic                        l1_ce_n;
  logic [l2_addr_bits-1:0]     l2_widx;
  l2_entry_t                   l2_rdata;
  logic                        l2_ce_n;

  // stage 1 registers
  logic [l2_addr_bits-1:0]     s1_l2_idx;
  logic [page_offset_bits-1:0] s1_offset;
  logic                        s1_valid;

  // top bits of va pick the level-1 entry
  assign l1_idx  = va[va_bits-1 -: l1_addr_bits];
  assign l1_ce_n = !l1_we;

  static_ram #(
    .word_t_p  (l1_entry_t),
    .addr_bits (l1_addr_bits)
  ) l1_ram (
    .WE_N  (WE_N),
    .addr  (l1_idx),
    .waddr (l1_idx),
    .wdata (l1_data),
    .ce_n  (l1_ce_n),
    .wr    (l1_we),
    .rdata (l1_rdata)
  );

  // write index uses the level-1 entry before this edge's level-1 write
  assign l2_widx = {l1_rdata, va[page_offset_bits +: l2_sel_bits]};
  assign l2_ce_n = !l2_we;

  // read address follows stage 1 and write address follows va
  static_ram #(
    .word_t_p  (l2_entry_t),
    .addr_bits (l2_addr_bits)
  ) l2_ram (
    .WE_N  (WE_N),
    .addr  (s1_l2_idx),
    .waddr (l2_widx),
    .wdata (l2_data),
    .ce_n  (l2_ce_n),
    .wr    (l2_we),
    .rdata (l2_rdata)
  );

  // stage 1 holds the level-1 entry plus offset
  always_ff @(posedge WE_N or negedge rst_n)
  begin
    if (!rst_n)
    begin
      s1_l2_idx <= '0;
      s1_offset <= '0;
      s1_valid  <= 1'b0;
    end
    else
    begin
      s1_valid <= lookup;
      if (lookup)
      begin
        s1_l2_idx <= l2_widx;
        s1_offset <= va[page_offset_bits-1:0];
      end
    end
  end

  // stage 2 holds the physical page and permission bits
  always_ff @(posedge WE_N or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pa       <= '0;
      access   <= 1'b0;
      writable <= 1'b0;
      pa_valid <= 1'b0;
    end
    else
    begin
      pa_valid <= s1_valid;
      if (s1_valid)
      begin
        pa       <= {l2_rdata[l2_page_msb:l2_page_lsb], s1_offset};
        access   <= l2_rdata[l2_access_bit];
        writable <= l2_rdata[l2_write_bit];
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/scratchpad.sv ====
// A memory and M memory with low A writes mirrored into M
`default_nettype none

module scratchpad
  import cadr_mem_pkg::*;
(
  input  logic                   WE_N,
  input  logic [a_addr_bits-1:0] a_addr,
  input  logic [m_addr_bits-1:0] m_addr,
  input  logic                   wr_en,
  input  logic [a_addr_bits-1:0] wr_addr,
  input  word_t                  wr_data,
  output word_t                  a_rdata,
  output word_t                  m_rdata
);

  logic a_ce_n;
  logic m_ce_n;
  logic m_hit;

  // M shadows A locations 0 to 31
  assign m_hit  = (wr_addr[a_addr_bits-1:m_addr_bits] == '0);

  // chip enables only go low on a write
  assign a_ce_n = !wr_en;
  assign m_ce_n = !(wr_en && m_hit);

  static_ram #(
    .word_t_p  (word_t),
    .addr_bits (a_addr_bits)
  ) a_ram (
    .WE_N  (WE_N),
    .addr  (a_addr),
    .waddr (wr_addr),
    .wdata (wr_data),
    .ce_n  (a_ce_n),
    .wr    (wr_en),
    .rdata (a_rdata)
  );

  // same data, low address bits only
  static_ram #(
    .word_t_p  (word_t),
    .addr_bits (m_addr_bits)
  ) m_ram (
    .WE_N  (WE_N),
    .addr  (m_addr),
    .waddr (wr_addr[m_addr_bits-1:0]),
    .wdata (wr_data),
    .ce_n  (m_ce_n),
    .wr    (wr_en),
    .rdata (m_rdata)
  );

endmodule

`default_nettype wire

// ==== logic/cadr_mem_top.sv ====
// top level joining the map and the scratchpad under one WE_N
`default_nettype none

module cadr_mem_top
  import cadr_mem_pkg::*;
(
  input  logic                   WE_N,
  input  logic                   rst_n,

  // map lookup and write side
  input  logic [va_bits-1:0]     va,
  input  logic                   lookup,
  input  logic                   l1_we,
  input  l1_entry_t              l1_data,
  input  logic                   l2_we,
  input  l2_entry_t              l2_data,
  output logic [pa_bits-1:0]     pa,
  output logic                   access,
  output logic                   writable,
  output logic                   pa_valid,

  // scratchpad side
  input  logic [a_addr_bits-1:0] a_addr,
  input  logic [m_addr_bits-1:0] m_addr,
  input  logic                   wr_en,
  input  logic [a_addr_bits-1:0] wr_addr,
  input  word_t                  wr_data,
  output word_t                  a_rdata,
  output word_t                  m_rdata
);

  map_translate map_i (
    .WE_N     (WE_N),
    .rst_n    (rst_n),
    .va       (va),
    .lookup   (lookup),
    .l1_we    (l1_we),
    .l1_data  (l1_data),
    .l2_we    (l2_we),
    .l2_data  (l2_data),
    .pa       (pa),
    .access   (access),
    .writable (writable),
    .pa_valid (pa_valid)
  );

  // A and M scratchpad memories
  scratchpad spad_i (
    .WE_N    (WE_N),
    .a_addr  (a_addr),
    .m_addr  (m_addr),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .a_rdata (a_rdata),
    .m_rdata (m_rdata)
  );

endmodule

`default_nettype wire

// ==== sim/mem_model.svh ====
// reference model of both maps, the A and M memories and the lookup pipeline
`ifndef MEM_MODEL_SVH
`define MEM_MODEL_SVH

  l1_entry_t m_l1 [2**l1_addr_bits];
  l2_entry_t m_l2 [2**l2_addr_bits];
  word_t     m_a  [2**a_addr_bits];
  word_t     m_m  [2**m_addr_bits];

  // lookups in flight as {valid, level-2 index, offset}, oldest first
  logic [l2_addr_bits+page_offset_bits:0] flight_q [$];

  logic [pa_bits-1:0] exp_pa;
  logic               exp_access;
  logic               exp_writable;
  logic               exp_valid;

  // memories start at zero, pipeline empty
  task automatic model_clear();
    foreach (m_l1[i])
      m_l1[i] = '0;
    foreach (m_l2[i])
      m_l2[i] = '0;
    foreach (m_a[i])
      m_a[i] = '0;
    foreach (m_m[i])
      m_m[i] = '0;
    flight_q.delete();
    exp_pa       = '0;
    exp_access   = 1'b0;
    exp_writable = 1'b0;
    exp_valid    = 1'b0;
  endtask

  // one rising WE_N, every read sees contents from before this edge
  task automatic model_edge();
    logic [l1_addr_bits-1:0]                l1_idx;
    logic [l2_addr_bits-1:0]                l2_idx;
    logic [l2_addr_bits+page_offset_bits:0] ent;
    l2_entry_t                              e;
    l1_idx = va[23:13];
    l2_idx = {m_l1[l1_idx], va[12:8]};
    flight_q.push_back({lookup, l2_idx, va[7:0]});
    // older lookup finishes against level 2 as it is during its second cycle
    if (flight_q.size() > 1)
    begin
      ent       = flight_q.pop_front();
      exp_valid = ent[18];
      if (ent[18])
      begin
        e            = m_l2[ent[17:8]];
        exp_pa       = {e[13:0], ent[7:0]};
        exp_access   = e[23];
        exp_writable = e[22];
      end
    end
    if (l2_we)
      m_l2[l2_idx] = l2_data;
    if (l1_we)
      m_l1[l1_idx] = l1_data;
    if (wr_en)
    begin
      m_a[wr_addr] = wr_data;
      // M holds a copy of A words 0 to 31
      if (wr_addr[9:5] == 5'd0)
        m_m[wr_addr[4:0]] = wr_data;
    end
  endtask

`endif

// ==== sim/tb_cadr_mem.sv ====
// testbench driving the map and scratchpad with random stimulus against a model
`default_nettype none

module tb_cadr_mem
  import cadr_mem_pkg::*;
();

  logic                   WE_N;
  logic                   rst_n;
  logic [va_bits-1:0]     va;
  logic                   lookup;
  logic                   l1_we;
  l1_entry_t              l1_data;
  logic                   l2_we;
  l2_entry_t              l2_data;
  logic [pa_bits-1:0]     pa;
  logic                   access;
  logic                   writable;
  logic                   pa_valid;
  logic [a_addr_bits-1:0] a_addr;
  logic [m_addr_bits-1:0] m_addr;
  logic                   wr_en;
  logic [a_addr_bits-1:0] wr_addr;
  word_t                  wr_data;
  word_t                  a_rdata;
  word_t                  m_rdata;

  int          errors;
  int          timeouts;
  int          edge_cnt;
  time         last_rise;
  int          n;
  logic [31:0] mix;

  `include "mem_model.svh"

  cadr_mem_top dut_i (
    .WE_N     (WE_N),
    .rst_n    (rst_n),
    .va       (va),
    .lookup   (lookup),
    .l1_we    (l1_we),
    .l1_data  (l1_data),
    .l2_we    (l2_we),
    .l2_data  (l2_data),
    .pa       (pa),
    .access   (access),
    .writable (writable),
    .pa_valid (pa_valid),
    .a_addr   (a_addr),
    .m_addr   (m_addr),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .a_rdata  (a_rdata),
    .m_rdata  (m_rdata)
  );

  initial
  begin
    WE_N = 1'b0;
    forever #2 WE_N = ~WE_N;
  end

  always @(posedge WE_N)
  begin
    edge_cnt++;
    last_rise = $time;
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    errors++;
    $display("Error: %s got %h expected %h at %0t", name, got, want, $time);
  endtask

  // returns 1 unit after the next rising WE_N
  task automatic next_edge();
    int start;
    int spins;
    start = edge_cnt;
    spins = 0;
    while (edge_cnt == start && spins < 10)
    begin
      #1;
      spins++;
    end
    if (edge_cnt == start)
    begin
      timeouts++;
      $display("timeout: no rising WE_N edge within 10 time units");
    end
    else
    begin
      #(last_rise + 1 - $time);
    end
  endtask

  // combinational reads before the edge and the registered lookup result after it
  task automatic cycle();
    #1;
    if (a_rdata !== m_a[a_addr])
      report_mismatch("a_rdata", a_rdata, m_a[a_addr]);
    if (m_rdata !== m_m[m_addr])
      report_mismatch("m_rdata", m_rdata, m_m[m_addr]);
    model_edge();
    next_edge();
    if (pa_valid !== exp_valid)
      report_mismatch("pa_valid", 32'(pa_valid), 32'(exp_valid));
    if (pa !== exp_pa)
      report_mismatch("pa", 32'(pa), 32'(exp_pa));
    if (access !== exp_access)
      report_mismatch("access", 32'(access), 32'(exp_access));
    if (writable !== exp_writable)
      report_mismatch("writable", 32'(writable), 32'(exp_writable));
  endtask

  task automatic drive_idle();
    lookup = 1'b0;
    l1_we  = 1'b0;
    l2_we  = 1'b0;
    wr_en  = 1'b0;
  endtask

  // 16 level-1 slots and 8 level-2 slots keep the hit rate up
  function automatic logic [va_bits-1:0] rand_va();
    logic [31:0] r;
    r = $urandom();
    return {7'd0, r[3:0], 2'd0, r[6:4], r[14:7]};
  endfunction

  task automatic drive_map(input logic lk, input logic w1, input logic w2);
    logic [31:0] r;
    r       = $urandom();
    // about half the cycles reuse the last va so writes meet lookups in flight
    va      = r[31] ? va : rand_va();
    lookup  = lk;
    l1_we   = w1;
    l2_we   = w2;
    l1_data = r[28:24];
    l2_data = r[23:0];
  endtask

  task automatic drive_spad(input logic w);
    logic [31:0] r;
    r = $urandom();
    // half the reads go back to the last write address
    a_addr  = r[11] ? wr_addr : r[21:12];
    m_addr  = r[11] ? wr_addr[4:0] : r[26:22];
    wr_en   = w;
    wr_addr = r[0] ? {5'd0, r[5:1]} : r[10:1];
    wr_data = $urandom();
  endtask

  initial
  begin
    errors   = 0;
    timeouts = 0;
    rst_n    = 1'b0;
    va       = '0;
    lookup   = 1'b0;
    l1_we    = 1'b0;
    l1_data  = '0;
    l2_we    = 1'b0;
    l2_data  = '0;
    a_addr   = '0;
    m_addr   = '0;
    wr_en    = 1'b0;
    wr_addr  = '0;
    wr_data  = '0;
    n        = $urandom(19);
    model_clear();
    repeat (8) next_edge();
    rst_n = 1'b1;
    if (pa_valid !== 1'b0)
      report_mismatch("pa_valid", 32'(pa_valid), 32'h0);
    if (pa !== '0)
      report_mismatch("pa", 32'(pa), 32'h0);

    // pa_valid must rise exactly 2 cycles after the first lookup
    drive_map(1'b1, 1'b0, 1'b0);
    cycle();
    drive_idle();
    n = 1;
    while (pa_valid !== 1'b1 && n < 8)
    begin
      cycle();
      n++;
    end
    if (n != 2)
    begin
      errors++;
      $display("pa_valid rose %0d cycles after the first lookup instead of 2", n);
    end

    repeat (40)
    begin
      drive_map(1'b0, 1'b1, 1'b0);
      cycle();
    end
    repeat (80)
    begin
      drive_map(1'b0, 1'b0, 1'b1);
      cycle();
    end
    repeat (80)
    begin
      drive_map(1'b1, 1'b0, 1'b0);
      cycle();
    end

    // scratchpad alone with unwritten words read first
    drive_idle();
    repeat (16)
    begin
      drive_spad(1'b0);
      cycle();
    end
    repeat (200)
    begin
      mix = $urandom();
      drive_spad(mix[0]);
      cycle();
    end

    // lookups mixed with map and scratchpad writes
    repeat (300)
    begin
      mix = $urandom();
      drive_map(mix[0] | mix[1], mix[2] & mix[3], mix[4] & mix[5]);
      drive_spad(mix[6]);
      cycle();
    end

    // level-2 write index comes from the level-1 entry already in place
    drive_idle();
    va      = 24'hfff234;
    l1_we   = 1'b1;
    l1_data = 5'h1b;
    cycle();
    l1_we   = 1'b0;
    l2_we   = 1'b1;
    l2_data = 24'hc02a5a;
    cycle();
    l2_we  = 1'b0;
    lookup = 1'b1;
    cycle();
    lookup = 1'b0;
    cycle();
    if (pa !== {14'h2a5a, 8'h34})
      report_mismatch("pa", 32'(pa), 32'({14'h2a5a, 8'h34}));
    if (access !== 1'b1 || writable !== 1'b1)
      report_mismatch("access,writable", 32'({access, writable}), 32'h3);
    repeat (2) cycle();

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+sim
logic/cadr_mem_pkg.sv
logic/static_ram.sv
logic/map_translate.sv
logic/scratchpad.sv
logic/cadr_mem_top.sv
sim/tb_cadr_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench and RTL with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f all.f --top-module tb_cadr_mem -o tb_cadr_mem
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_cadr_mem > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Simulation PASSED" "$log"; then
  exit 0
fi

echo "pass line not found in $log"
exit 1
